// File: build.f
hdl/tap_pkg.sv
hdl/beat_regs.sv
hdl/game_control.sv
hdl/box_painter.sv
hdl/status_display.sv
hdl/tap_top.sv
sim/tap_checker.sv
sim/tap_assert.sv
sim/tap_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the tap game testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tap_tb -f build.f -o tap_sim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tap_sim > sim.log 2>&1 || echo "CHECKS FAILED" >> sim.log
cat sim.log
! grep -q "CHECKS FAILED" sim.log && grep -q "ALL CHECKS PASSED" sim.log \
	&& echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: sim/tap_cases.txt
// One note per line as three hex digits: lane, speed, action
// Lane 0 is a rest; action 0 none, 1 hit, 2 wrong lane key
111
232
000
311
122
201
332
112
221
300
132
211
000
321
112
202

// File: sim/tap_tb.sv
`timescale 1ns/1ns
module tap_tb;
	import tap_pkg::*;

	localparam int NOTES = 16;
	localparam int SCALE = 2;
	localparam int LIMIT = NOTES * 120 * (4 * SCALE + 130) + 20000;

	logic Clock, rst, start, psel, penable, pwrite;
	logic [2:0] keys;
	logic [4:0] paddr;
	logic [7:0] pwdata, prdata;
	logic plot, miss_flag, game_over;
	logic [7:0] px;
	logic [6:0] py;
	logic [8:0] colour;
	logic [6:0] hex0, hex1, hex2, hex3, hex4, hex5;
	logic [11:0] cases [NOTES];
	logic [11:0] cur_case;
	logic [6:0] draw_row = '0;
	logic drawing = 1'b0;
	logic all_keys = 1'b0; // Player holds every key
	int cycles = 0;

	tap_top #(.DEPTH(NOTES), .STEP_SCALE(SCALE)) DUT (
		.Clock(Clock), .rst(rst), .start(start), .keys(keys), .psel(psel),
		.penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .plot(plot), .px(px), .py(py), .colour(colour),
		.miss_flag(miss_flag), .game_over(game_over), .hex0(hex0), .hex1(hex1),
		.hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
	);

	assign cur_case = cases[DUT.u_ctrl.note_addr]; // Note being played

	tap_checker chk (
		.Clock(Clock), .rst(rst), .start(start), .plot(plot), .px(px), .py(py),
		.colour(colour), .game_over(game_over), .exp_lane(cur_case[9:8]),
		.exp_hit(cur_case[3:0] == 4'd1)
	);

	initial begin
		Clock = 1'b0;
		forever #4 Clock = ~Clock;
	end

	always @(posedge Clock) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: run exceeded %0d cycles", LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// Player holds a key while the drawn square is in rows 92 to 100
	function automatic logic [2:0] press_keys(input logic [11:0] c, input logic [6:0] row);
		logic [1:0] lane;
		logic [3:0] act;
		lane = c[9:8];
		act = c[3:0];
		press_keys = 3'b000;
		if (lane != 2'd0 && row >= 7'd92 && row <= 7'd100) begin
			if (act == 4'd1)
				press_keys = 3'b001 << (lane - 2'd1);
			else if (act == 4'd2)
				press_keys = 3'b001 << (lane % 3); // Neighbouring lane
		end
	endfunction

	always @(negedge Clock) begin
		if (plot && colour != 9'd0 && !drawing)
			draw_row = py; // Top row of a new draw pass
		drawing = plot && colour != 9'd0;
		keys = all_keys ? 3'b111 : press_keys(cur_case, draw_row);
	end

	task automatic write_reg(input logic [4:0] a, input logic [7:0] d);
		@(negedge Clock);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = a;
		pwdata = d;
		@(negedge Clock);
		penable = 1'b1;
		@(negedge Clock);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic read_reg(input logic [4:0] a, output logic [7:0] d);
		@(negedge Clock);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = a;
		@(negedge Clock);
		penable = 1'b1;
		#2 d = prdata;
		@(negedge Clock);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic expect_reg(input logic [4:0] a, input int expv, input string name);
		logic [7:0] d;
		read_reg(a, d);
		chk.check_val(name, expv, int'(d));
	endtask

	initial begin
		int exp_score;
		int exp_miss;
		int lane;
		int act;
		bit ended;
		rst = 1'b1;
		start = 1'b0;
		keys = 3'b000;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		exp_score = 0;
		exp_miss = 0;
		ended = 1'b0;
		$readmemh("sim/tap_cases.txt", cases);
		repeat (4) @(posedge Clock);
		@(negedge Clock) rst = 1'b0;

		expect_reg(5'd16, 0, "score");
		expect_reg(5'd17, 0, "misses");
		expect_reg(5'd18, 0, "state");
		for (int i = 0; i < NOTES; i++)
			write_reg(5'(i), {4'd0, cases[i][5:4], cases[i][9:8]});
		for (int i = 0; i < NOTES; i++)
			expect_reg(5'(i), int'({cases[i][5:4], cases[i][9:8]}), $sformatf("entry %0d", i));
		chk.end_test("table readback");

		repeat (40) @(negedge Clock);
		expect_reg(5'd18, 0, "state");
		chk.end_test("idle");

		@(negedge Clock) start = 1'b1;
		for (int n = 0; n < NOTES; n++) begin
			lane = int'(cases[n][9:8]);
			act = int'(cases[n][3:0]);
			if (lane != 0 && act == 1)
				exp_score++;
			else if (lane != 0)
				exp_miss++;
			while (DUT.u_ctrl.note_addr == 4'(n) && !game_over)
				@(negedge Clock);
			if (game_over) begin
				ended = 1'b1;
				break;
			end
			// Miss flag still holds until the next note loads
			chk.check_val("miss_flag", int'(lane != 0 && act != 1), int'(miss_flag));
			if (lane != 0 && act != 1)
				chk.check_val("hex3..hex0", int'({SEG_O, SEG_U, SEG_C, SEG_H}),
					int'({hex3, hex2, hex1, hex0}));
			else
				chk.check_val("hex3..hex0", int'({4{SEG_BLANK}}), int'({hex3, hex2, hex1, hex0}));
			chk.check_val("hex5", int'(SEG_HEX[exp_score / 16]), int'(hex5));
			chk.check_val("hex4", int'(SEG_HEX[exp_score % 16]), int'(hex4));
			expect_reg(5'd16, exp_score, "score");
			expect_reg(5'd17, exp_miss, "misses");
			chk.end_test($sformatf("note %0d", n));
		end

		if (!ended) begin
			chk.report("game did not end after the sixth miss");
		end else begin
			repeat (3) @(negedge Clock);
			chk.check_val("game_over", 1, int'(game_over));
			chk.check_val("hex3..hex0", int'({SEG_BLANK, SEG_B, SEG_Y, SEG_E}),
				int'({hex3, hex2, hex1, hex0}));
			expect_reg(5'd17, int'(MISS_LIMIT), "misses");
			expect_reg(5'd18, 4, "state");
			expect_reg(5'd16, exp_score, "score");
			all_keys = 1'b1; // Keys pressed after game over must not score
			repeat (300) @(negedge Clock);
			all_keys = 1'b0;
			expect_reg(5'd16, exp_score, "score");
			chk.check_val("hex4", int'(SEG_HEX[exp_score % 16]), int'(hex4));
		end
		chk.end_test("game over");

		$display("checks: %0d, errors: %0d, pixel passes: %0d",
			chk.checks, chk.errors, chk.passes);
		if (chk.errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: sim/tap_assert.sv
`timescale 1ns/1ns
module tap_assert import tap_pkg::*; (
	input logic Clock,
	input logic rst,
	input game_state_t state,
	input logic plot,
	input logic step_go,
	input logic step_done,
	input logic [2:0] misses
);

	logic busy; // Painter between step_go and step_done

	always_ff @(posedge Clock) begin
		if (rst)
			busy <= 1'b0;
		else if (step_go)
			busy <= 1'b1;
		else if (step_done)
			busy <= 1'b0;
	end

	a_idle_quiet: assert property (@(posedge Clock) disable iff (rst) state == G_IDLE |-> !plot)
		else $error("pixel write in idle");
	a_go_idle: assert property (@(posedge Clock) disable iff (rst) step_go |-> !busy)
		else $error("step_go while the painter is busy");
	a_miss_max: assert property (@(posedge Clock) disable iff (rst) misses <= MISS_LIMIT)
		else $error("miss count above limit");
	a_reset: assert property (@(posedge Clock) rst |=> state == G_IDLE && misses == 3'd0)
		else $error("wrong state after reset");

endmodule

bind tap_top tap_assert u_assert (
	.Clock(Clock), .rst(rst), .state(state), .plot(plot),
	.step_go(step_go), .step_done(step_done), .misses(misses)
);

// File: sim/tap_checker.sv
`timescale 1ns/1ns
module tap_checker import tap_pkg::*; (
	input logic Clock,
	input logic rst,
	input logic start,
	input logic plot,
	input logic [7:0] px,
	input logic [6:0] py,
	input logic [8:0] colour,
	input logic game_over,
	input logic [1:0] exp_lane,
	input logic exp_hit
);

	int errors = 0;
	int checks = 0;
	int mark = 0;   // Error count when the current test began
	int passes = 0;
	logic in_pass = 1'b0;
	logic last_draw = 1'b1; // Previous pass drew the box
	int last_row = 119;
	int npix;
	logic [63:0] mask;
	int x0;
	int y0;
	int dx;
	int dy;
	logic [8:0] col0;

	task automatic check_val(input string name, input int expv, input int actv);
		checks++;
		if (expv !== actv) begin
			errors++;
			$display("FAILED at %0t ns: %s expected %0h got %0h", $time, name, expv, actv);
		end
	endtask

	task automatic report(input string msg);
		errors++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	task automatic end_test(input string name);
		if (errors == mark)
			$display("test %s passed", name);
		else
			$display("test %s failed with %0d errors", name, errors - mark);
		mark = errors;
	endtask

	// Colour of a draw pass from its top row
	function automatic int draw_colour(input int row, input logic hit);
		if (row < 101)
			return int'(COL_FALL);
		return hit ? int'(COL_HIT) : int'(COL_MISS);
	endfunction

	// Pixel passes sampled mid cycle
	always @(negedge Clock) begin
		if (rst) begin
			in_pass = 1'b0;
			last_draw = 1'b1;
			last_row = 119;
		end else if (plot) begin
			if (!start) report("pixel write before start");
			if (game_over) report("pixel write after game over");
			if (exp_lane == 2'd0) report("pixel write during a rest note");
			if (!in_pass) begin
				in_pass = 1'b1;
				npix = 0;
				mask = '0;
				x0 = int'(exp_lane) * 30; // Lane columns 30, 60, 90
				y0 = int'(py);
				col0 = colour;
			end
			dx = int'(px) - x0;
			dy = int'(py) - y0;
			if (dx < 0 || dx > 7 || dy < 0 || dy > 7)
				report("pixel outside the lane square");
			else
				mask[dy * 8 + dx] = 1'b1;
			if (colour != col0) report("colour changed within a pass");
			npix++;
		end else if (in_pass) begin
			in_pass = 1'b0;
			passes++;
			check_val("pass pixel count", 64, npix);
			if (!(&mask)) report("pass left part of the square unpainted");
			// A drawn box is erased before it moves unless it sits on the last row
			if (last_draw && last_row != 119) begin
				check_val("erase colour", 0, int'(col0));
				check_val("erase row", last_row, y0);
				last_draw = 1'b0;
			end else begin
				check_val("draw row", last_draw ? 0 : last_row + 1, y0);
				check_val("colour", draw_colour(y0, exp_hit), int'(col0));
				last_draw = 1'b1;
			end
			last_row = y0;
		end
	end

endmodule

// File: hdl/tap_top.sv
`timescale 1ns/1ns
module tap_top import tap_pkg::*; #(
	parameter int DEPTH = 16,
	parameter int STEP_SCALE = 100
) (
	input  logic Clock,
	input  logic rst,
	input  logic start,
	input  logic [2:0] keys,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [4:0] paddr,
	input  logic [7:0] pwdata,
	output logic [7:0] prdata,
	output logic plot,
	output logic [7:0] px,
	output logic [6:0] py,
	output logic [8:0] colour,
	output logic miss_flag,
	output logic game_over,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5
);

	logic [$clog2(DEPTH)-1:0] note_addr;
	lane_t note_lane;
	logic [SPEED_W-1:0] note_speed;
	logic [7:0] score;
	logic [2:0] misses;
	game_state_t state;
	logic step_go, new_note, step_done;
	col_sel_t col_sel;
	logic [6:0] box_row;

	beat_regs #(.DEPTH(DEPTH)) u_regs (
		.Clock(Clock), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .note_addr(note_addr),
		.score(score), .misses(misses), .state(state),
		.note_lane(note_lane), .note_speed(note_speed)
	);

	game_control #(.DEPTH(DEPTH), .STEP_SCALE(STEP_SCALE)) u_ctrl (
		.Clock(Clock), .rst(rst), .start(start), .keys(keys),
		.note_lane(note_lane), .note_speed(note_speed),
		.step_done(step_done), .box_row(box_row), .note_addr(note_addr),
		.step_go(step_go), .new_note(new_note), .col_sel(col_sel),
		.score(score), .misses(misses), .miss_flag(miss_flag),
		.game_over(game_over), .state(state)
	);

	box_painter u_paint (
		.Clock(Clock), .rst(rst), .step_go(step_go), .new_note(new_note),
		.note_lane(note_lane), .col_sel(col_sel), .step_done(step_done),
		.box_row(box_row), .plot(plot), .px(px), .py(py), .colour(colour)
	);

	status_display u_disp (
		.Clock(Clock), .rst(rst), .miss_flag(miss_flag), .game_over(game_over),
		.score(score), .hex0(hex0), .hex1(hex1), .hex2(hex2),
		.hex3(hex3), .hex4(hex4), .hex5(hex5)
	);

endmodule

// File: hdl/status_display.sv
`timescale 1ns/1ns
module status_display import tap_pkg::*; (
	input  logic Clock,
	input  logic rst,
	input  logic miss_flag,
	input  logic game_over,
	input  logic [7:0] score,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5
);

	// Message digits
	always_ff @(posedge Clock) begin
		if (rst) begin
			{hex3, hex2, hex1, hex0} <= {4{SEG_BLANK}};
		end else if (game_over) begin
			{hex3, hex2, hex1, hex0} <= {SEG_BLANK, SEG_B, SEG_Y, SEG_E}; // BYE
		end else if (miss_flag) begin
			{hex3, hex2, hex1, hex0} <= {SEG_O, SEG_U, SEG_C, SEG_H}; // OUCH
		end else begin
			{hex3, hex2, hex1, hex0} <= {4{SEG_BLANK}};
		end
	end

	// Score in hex, high nibble on the left
	always_ff @(posedge Clock) begin
		if (rst) begin
			hex5 <= SEG_HEX[0];
			hex4 <= SEG_HEX[0];
		end else begin
			hex5 <= SEG_HEX[score[7:4]];
			hex4 <= SEG_HEX[score[3:0]];
		end
	end

endmodule

// File: hdl/box_painter.sv
`timescale 1ns/1ns
module box_painter import tap_pkg::*; (
	input  logic Clock,
	input  logic rst,
	input  logic step_go,
	input  logic new_note,
	input  lane_t note_lane,
	input  col_sel_t col_sel,
	output logic step_done,
	output logic [6:0] box_row,
	output logic plot,
	output logic [7:0] px,
	output logic [6:0] py,
	output logic [8:0] colour
);

	localparam int OFS_W = $clog2(BOX_SIZE);
	localparam int CNT_W = 2 * OFS_W;

	paint_state_t pstate;
	logic [CNT_W-1:0] cnt; // Low bits column offset, high bits row offset
	lane_t lane_q;
	logic [8:0] col_q;
	logic fresh;

	always_ff @(posedge Clock) begin
		if (rst) begin
			pstate <= P_IDLE;
			cnt <= '0;
			step_done <= 1'b0;
			box_row <= '0;
			fresh <= 1'b0;
		end else begin
			step_done <= 1'b0;
			case (pstate)
				P_IDLE: begin
					if (step_go) begin
						fresh <= new_note;
						cnt <= '0;
						pstate <= new_note ? P_MOVE : P_ERASE; // Nothing to erase for a new box
					end
				end
				P_ERASE: begin
					cnt <= cnt + 1'b1;
					if (&cnt)
						pstate <= P_MOVE;
				end
				P_MOVE: begin
					box_row <= fresh ? '0 : box_row + 7'd1;
					pstate <= P_DRAW;
				end
				P_DRAW: begin
					cnt <= cnt + 1'b1;
					if (&cnt) begin
						pstate <= P_IDLE;
						step_done <= 1'b1;
					end
				end
				default: pstate <= P_IDLE;
			endcase
		end
	end

	// Lane and colour for the whole step
	always_ff @(posedge Clock) begin
		if (pstate == P_IDLE && step_go) begin
			lane_q <= note_lane;
			case (col_sel)
				C_HIT:   col_q <= COL_HIT;
				C_MISS:  col_q <= COL_MISS;
				default: col_q <= COL_FALL;
			endcase
		end
	end

	// Rest notes sweep silently
	assign plot = (pstate == P_ERASE || pstate == P_DRAW) && lane_q != LANE_REST;
	assign px = LANE_X[lane_q] + 8'(cnt[OFS_W-1:0]);
	assign py = box_row + 7'(cnt[CNT_W-1:OFS_W]);
	assign colour = (pstate == P_ERASE) ? COL_ERASE : col_q;

endmodule

// File: hdl/game_control.sv
`timescale 1ns/1ns
module game_control import tap_pkg::*; #(
	parameter int DEPTH = 16,
	parameter int STEP_SCALE = 100
) (
	input  logic Clock,
	input  logic rst,
	input  logic start,
	input  logic [2:0] keys,
	input  lane_t note_lane,
	input  logic [SPEED_W-1:0] note_speed,
	input  logic step_done,
	input  logic [6:0] box_row,
	output logic [$clog2(DEPTH)-1:0] note_addr,
	output logic step_go,
	output logic new_note,
	output col_sel_t col_sel,
	output logic [7:0] score,
	output logic [2:0] misses,
	output logic miss_flag,
	output logic game_over,
	output game_state_t state
);

	localparam int AW = $clog2(DEPTH);
	localparam int TW = $clog2(4 * STEP_SCALE + 1) + 1;

	logic [TW-1:0] tick;
	logic [TW-1:0] period;
	logic tick_done;
	logic painted;   // Painter finished the current step
	logic hit_done;  // Current note already scored
	logic key_on;
	logic judged;    // Note is not a rest

	assign period = TW'(STEP_PERIOD[note_speed] * STEP_SCALE);
	assign tick_done = tick >= period;
	assign judged = note_lane != LANE_REST;
	assign game_over = state == G_OVER;

	// Key of the current lane
	always_comb begin
		case (note_lane)
			LANE_LEFT:  key_on = keys[0];
			LANE_MID:   key_on = keys[1];
			LANE_RIGHT: key_on = keys[2];
			default:    key_on = 1'b0;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= G_IDLE;
			note_addr <= '0;
			step_go <= 1'b0;
			new_note <= 1'b0;
			col_sel <= C_FALL;
			score <= '0;
			misses <= '0;
			miss_flag <= 1'b0;
			tick <= '0;
			painted <= 1'b0;
			hit_done <= 1'b0;
		end else begin
			step_go <= 1'b0;
			if (!tick_done)
				tick <= tick + 1'b1;
			if (step_done && state == G_WAIT) begin
				painted <= 1'b1;
				if (judged && box_row >= HIT_TOP && box_row <= HIT_BOTTOM && key_on && !hit_done) begin
					hit_done <= 1'b1;
					score <= score + 1'b1;
				end
				if (judged && box_row == HIT_BOTTOM + 7'd1 && !hit_done) begin
					miss_flag <= 1'b1;
					misses <= misses + 1'b1;
				end
			end
			case (state)
				G_IDLE: if (start) state <= G_LOAD;
				G_LOAD: begin
					step_go <= 1'b1;
					new_note <= 1'b1; // Painter places the box at the top
					col_sel <= C_FALL;
					hit_done <= 1'b0;
					miss_flag <= 1'b0;
					tick <= '0;
					painted <= 1'b0;
					state <= G_WAIT;
				end
				G_WAIT: begin
					if (misses >= MISS_LIMIT) begin
						state <= G_OVER;
					end else if (painted && tick_done) begin
						if (box_row == LAST_ROW) begin
							note_addr <= (note_addr == AW'(DEPTH - 1)) ? '0 : note_addr + 1'b1;
							state <= G_LOAD;
						end else begin
							state <= G_STEP;
						end
					end
				end
				G_STEP: begin
					step_go <= 1'b1;
					new_note <= 1'b0;
					// Colour is chosen for the row about to be drawn
					if (box_row + 7'd1 > HIT_BOTTOM)
						col_sel <= hit_done ? C_HIT : C_MISS;
					else
						col_sel <= C_FALL;
					tick <= '0;
					painted <= 1'b0;
					state <= G_WAIT;
				end
				G_OVER: state <= G_OVER; // Only rst leaves
				default: state <= G_IDLE;
			endcase
		end
	end

endmodule

// File: hdl/beat_regs.sv
`timescale 1ns/1ns
module beat_regs import tap_pkg::*; #(
	parameter int DEPTH = 16
) (
	input  logic Clock,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [4:0] paddr,
	input  logic [7:0] pwdata,
	output logic [7:0] prdata,
	input  logic [$clog2(DEPTH)-1:0] note_addr,
	input  logic [7:0] score,
	input  logic [2:0] misses,
	input  game_state_t state,
	output lane_t note_lane,
	output logic [SPEED_W-1:0] note_speed
);

	localparam int AW = $clog2(DEPTH);
	localparam int ENTRY_W = SPEED_W + 2; // Speed above the lane
	localparam logic [4:0] ADDR_SCORE = 5'd16;
	localparam logic [4:0] ADDR_MISSES = 5'd17;
	localparam logic [4:0] ADDR_STATE = 5'd18;

	logic [ENTRY_W-1:0] beat_tbl [DEPTH];
	logic in_table;
	logic wr_en;

	assign in_table = paddr < 5'(DEPTH);
	assign wr_en = psel && penable && pwrite && in_table; // Status addresses are read only

	always_ff @(posedge Clock) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++)
				beat_tbl[i] <= '0; // All rests
		end else if (wr_en) begin
			beat_tbl[paddr[AW-1:0]] <= pwdata[ENTRY_W-1:0];
		end
	end

	// APB read path
	always_comb begin
		prdata = '0;
		if (in_table) begin
			prdata = 8'(beat_tbl[paddr[AW-1:0]]);
		end else begin
			case (paddr)
				ADDR_SCORE:  prdata = score;
				ADDR_MISSES: prdata = {5'd0, misses};
				ADDR_STATE:  prdata = {5'd0, state};
				default:     prdata = '0;
			endcase
		end
	end

	// Game side read port
	assign note_lane = lane_t'(beat_tbl[note_addr][1:0]);
	assign note_speed = beat_tbl[note_addr][ENTRY_W-1:2];

endmodule

// File: hdl/tap_pkg.sv
package tap_pkg;

	typedef enum logic [2:0] {G_IDLE, G_LOAD, G_WAIT, G_STEP, G_OVER} game_state_t;
	typedef enum logic [1:0] {P_IDLE, P_ERASE, P_MOVE, P_DRAW} paint_state_t;
	typedef enum logic [1:0] {LANE_REST, LANE_LEFT, LANE_MID, LANE_RIGHT} lane_t;
	typedef enum logic [1:0] {C_FALL, C_HIT, C_MISS} col_sel_t;

	localparam int SPEED_W = 2;
	localparam int BOX_SIZE = 8;

	// Column of each lane, entry 0 is the rest lane
	localparam logic [3:0][7:0] LANE_X = {8'd90, 8'd60, 8'd30, 8'd0};

	localparam logic [6:0] HIT_TOP = 7'd90;
	localparam logic [6:0] HIT_BOTTOM = 7'd100;
	localparam logic [6:0] LAST_ROW = 7'd119;
	localparam logic [2:0] MISS_LIMIT = 3'd6;

	// Base step period per speed code, slowest first
	localparam logic [3:0][3:0] STEP_PERIOD = {4'd1, 4'd2, 4'd3, 4'd4};

	localparam logic [8:0] COL_FALL = 9'b111000000;
	localparam logic [8:0] COL_HIT = 9'b000000111;
	localparam logic [8:0] COL_MISS = 9'b000111000;
	localparam logic [8:0] COL_ERASE = 9'b000000000;

	// Segment patterns, active low, bit 6 is segment g
	localparam logic [6:0] SEG_H = 7'b0001001;
	localparam logic [6:0] SEG_C = 7'b1000110;
	localparam logic [6:0] SEG_U = 7'b1000001;
	localparam logic [6:0] SEG_O = 7'b1000000;
	localparam logic [6:0] SEG_B = 7'b0000011;
	localparam logic [6:0] SEG_Y = 7'b0010001;
	localparam logic [6:0] SEG_E = 7'b0000110;
	localparam logic [6:0] SEG_BLANK = 7'b1111111;

	localparam logic [15:0][6:0] SEG_HEX = {
		7'b0001110, 7'b0000110, 7'b0100001, 7'b1000110, // F E d C
		7'b0000011, 7'b0001000, 7'b0010000, 7'b0000000, // b A 9 8
		7'b1111000, 7'b0000010, 7'b0010010, 7'b0011001, // 7 6 5 4
		7'b0110000, 7'b0100100, 7'b1111001, 7'b1000000  // 3 2 1 0
	};

endpackage
